// ==== Makefile ====
# Verilator build of the serial link loopback testbench

TOP = tb_slink

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f vlog.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

// ==== slink.sv ====
/*
 * Top level of the single-channel serial link. Connects the register block,
 * the transmit and receive data link halves and the physical layer.
 */
`timescale 1ns/1ns

module slink (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  slink_pkg::data_t     data_i,
  input  logic                 data_valid_i,
  output logic                 data_ready_o,
  output slink_pkg::data_t     data_o,
  output logic                 data_valid_o,
  input  logic                 data_ready_i,
  input  logic                 reg_req_i,
  input  logic                 reg_we_i,
  input  slink_pkg::reg_addr_t reg_addr_i,
  input  slink_pkg::data_t     reg_wdata_i,
  output slink_pkg::data_t     reg_rdata_o,
  output logic                 reg_rvalid_o,
  input  logic                 ddr_rcv_clk_i,
  output logic                 ddr_rcv_clk_o,
  input  slink_pkg::flit_t     ddr_i,
  output slink_pkg::flit_t     ddr_o,
  output logic                 clk_ena_o,
  output logic                 reset_no
);

  import slink_pkg::*;

  logic     link_en;
  clk_div_t clk_div;
  logic     fc_clear;
  credit_t  tx_credit;
  credit_t  rx_fill;
  flit_t    tx_flit;
  logic     tx_flit_valid;
  logic     tx_flit_ready;
  flit_t    rx_flit;
  logic     rx_flit_valid;
  credit_t  ret_credit;
  logic     ret_credit_taken;
  credit_t  rcv_credit;
  logic     rcv_credit_valid;

  //////////////////////////////
  // Configuration registers
  //////////////////////////////

  slink_reg i_reg (
    .clk_i, .arst_n_i, .reg_req_i, .reg_we_i, .reg_addr_i, .reg_wdata_i,
    .reg_rdata_o, .reg_rvalid_o,
    .tx_credit_i (tx_credit),
    .rx_fill_i   (rx_fill),
    .link_en_o   (link_en),
    .clk_div_o   (clk_div),
    .fc_clear_o  (fc_clear),
    .clk_ena_o, .reset_no
  );

  //////////////////////////////
  // Data link layer
  //////////////////////////////

  slink_link_tx i_link_tx (
    .clk_i, .arst_n_i,
    .link_en_i          (link_en),
    .fc_clear_i         (fc_clear),
    .data_i, .data_valid_i, .data_ready_o,
    .ret_credit_i       (ret_credit),
    .ret_credit_taken_o (ret_credit_taken),
    .rcv_credit_i       (rcv_credit),
    .rcv_credit_valid_i (rcv_credit_valid),
    .credit_o           (tx_credit),
    .tx_flit_o          (tx_flit),
    .tx_flit_valid_o    (tx_flit_valid),
    .tx_flit_ready_i    (tx_flit_ready)
  );

  slink_link_rx i_link_rx (
    .clk_i, .arst_n_i,
    .fc_clear_i         (fc_clear),
    .rx_flit_i          (rx_flit),
    .rx_flit_valid_i    (rx_flit_valid),
    .data_o, .data_valid_o, .data_ready_i,
    .ret_credit_o       (ret_credit),
    .ret_credit_taken_i (ret_credit_taken),
    .rcv_credit_o       (rcv_credit),
    .rcv_credit_valid_o (rcv_credit_valid),
    .fill_o             (rx_fill)
  );

  //////////////////////////////
  // Physical layer
  //////////////////////////////

  slink_phy i_phy (
    .clk_i, .arst_n_i,
    .link_en_i       (link_en),
    .clk_div_i       (clk_div),
    .tx_flit_i       (tx_flit),
    .tx_flit_valid_i (tx_flit_valid),
    .tx_flit_ready_o (tx_flit_ready),
    .ddr_rcv_clk_o, .ddr_o, .ddr_rcv_clk_i, .ddr_i,
    .rx_flit_o       (rx_flit),
    .rx_flit_valid_o (rx_flit_valid)
  );

endmodule

// ==== slink_config.svh ====
/*
 * Build-time constants of the serial link.
 * Include this wherever lane, word or credit sizes or register addresses are needed.
 */
`ifndef SLINK_CONFIG_SVH
`define SLINK_CONFIG_SVH

// Physical layer
`define SLINK_NUM_LANES 8
`define SLINK_CLK_DIV_RST 4

// Data link layer
`define SLINK_DATA_W 32
`define SLINK_NUM_CREDITS 8
`define SLINK_FRAME_FLITS 5

// Register word addresses
`define SLINK_REG_CTRL 2'd0
`define SLINK_REG_CLK_DIV 2'd1
`define SLINK_REG_STATUS 2'd2

`endif

// ==== slink_link_rx.sv ====
/*
 * Receive half of the data link. Assembles flits into frames, forwards the
 * credit field, stores data words in the receive FIFO and counts freed slots.
 */
`timescale 1ns/1ns
`include "slink_config.svh"

module slink_link_rx (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               fc_clear_i,
  input  slink_pkg::flit_t   rx_flit_i,
  input  logic               rx_flit_valid_i,
  output slink_pkg::data_t   data_o,
  output logic               data_valid_o,
  input  logic               data_ready_i,
  output slink_pkg::credit_t ret_credit_o,
  input  logic               ret_credit_taken_i,
  output slink_pkg::credit_t rcv_credit_o,
  output logic               rcv_credit_valid_o,
  output slink_pkg::credit_t fill_o
);

  import slink_pkg::*;

  localparam int unsigned Depth    = `SLINK_NUM_CREDITS;
  localparam int unsigned PtrW     = $clog2(Depth);
  localparam int unsigned FrameW   = $bits(frame_t);
  localparam int unsigned LastFlit = `SLINK_FRAME_FLITS - 1;

  rx_state_e       state_q;
  rx_state_e       state_d;
  logic [2:0]      flit_cnt_q;
  frame_t          frame_q;
  logic            frame_done_q;
  tag_e            tag;
  logic            push;
  logic            pop;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  credit_t         count_q;
  credit_t         ret_q;
  data_t           mem_q [Depth];

  //////////////////////////////
  // Flit assembler
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      RX_IDLE: if (rx_flit_valid_i) state_d = RX_COLLECT;
      RX_COLLECT: begin
        if (rx_flit_valid_i && (flit_cnt_q == 3'(LastFlit))) begin
          state_d = RX_IDLE;
        end
      end
      default: state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= RX_IDLE;
      flit_cnt_q   <= '0;
      frame_done_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      frame_done_q <= rx_flit_valid_i && (state_q == RX_COLLECT) &&
                      (flit_cnt_q == 3'(LastFlit));
      if (rx_flit_valid_i) begin
        flit_cnt_q <= (state_q == RX_IDLE) ? 3'd1 : flit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_flit_valid_i) begin
      frame_q <= {frame_q[FrameW-`SLINK_NUM_LANES-1:0], rx_flit_i};
    end
  end

  assign tag                = tag_e'(frame_q[FrameW-1]);
  assign rcv_credit_o       = frame_q[FrameW-2 -: $bits(credit_t)];
  assign rcv_credit_valid_o = frame_done_q;
  assign push               = frame_done_q && (tag == TAG_DATA);

  //////////////////////////////
  // Receive FIFO
  //////////////////////////////

  assign data_valid_o = (count_q != '0);
  assign data_o       = mem_q[rd_ptr_q];
  assign pop          = data_valid_o && data_ready_i;
  assign fill_o       = count_q;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= frame_q[`SLINK_DATA_W-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ret_q    <= '0;
    end else if (fc_clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ret_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PtrW'(push);
      rd_ptr_q <= rd_ptr_q + PtrW'(pop);
      count_q  <= count_q + credit_t'(push) - credit_t'(pop);
      // Freed slots wait here until a frame picks them up
      if (ret_credit_taken_i) begin
        ret_q <= credit_t'(pop);
      end else if (pop) begin
        ret_q <= ret_q + 1'b1;
      end
    end
  end

  assign ret_credit_o = ret_q;

  // Far-end credit accounting keeps a free slot for every data frame
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push |-> (count_q < credit_t'(Depth)));

endmodule

// ==== slink_link_tx.sv ====
/*
 * Transmit half of the data link. Packs stream words or returned credits
 * into frames, tracks the remote FIFO credits and hands flits to the PHY.
 */
`timescale 1ns/1ns
`include "slink_config.svh"

module slink_link_tx (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               link_en_i,
  input  logic               fc_clear_i,
  input  slink_pkg::data_t   data_i,
  input  logic               data_valid_i,
  output logic               data_ready_o,
  input  slink_pkg::credit_t ret_credit_i,
  output logic               ret_credit_taken_o,
  input  slink_pkg::credit_t rcv_credit_i,
  input  logic               rcv_credit_valid_i,
  output slink_pkg::credit_t credit_o,
  output slink_pkg::flit_t   tx_flit_o,
  output logic               tx_flit_valid_o,
  input  logic               tx_flit_ready_i
);

  import slink_pkg::*;

  localparam int unsigned LastFlit = `SLINK_FRAME_FLITS - 1;

  credit_t    credit_q;
  credit_t    credit_d;
  logic       busy_q;
  logic [2:0] flit_cnt_q;
  frame_t     frame_q;
  frame_t     frame_d;
  data_t      payload;
  tag_e       tag;
  logic       send_data;
  logic       send_credit;
  logic       start;
  logic       flit_last;

  //////////////////////////////
  // Frame selection
  //////////////////////////////

  assign data_ready_o = link_en_i && !busy_q && (credit_q != '0);
  assign send_data    = data_valid_i && data_ready_o;
  // Credit-only frame when there is nothing to carry but freed slots
  assign send_credit  = link_en_i && !busy_q && !send_data && (ret_credit_i != '0);
  assign start        = send_data || send_credit;

  // Every frame carries the pending credits, so both kinds consume them
  assign ret_credit_taken_o = start;

  assign tag     = send_data ? TAG_DATA : TAG_CREDIT;
  assign payload = send_data ? data_i : '0;
  assign frame_d = {tag, ret_credit_i, 3'b000, payload};

  //////////////////////////////
  // Credit counter
  //////////////////////////////

  always_comb begin
    credit_d = credit_q;
    if (fc_clear_i) begin
      credit_d = credit_t'(`SLINK_NUM_CREDITS);
    end else begin
      if (send_data) begin
        credit_d = credit_d - 1'b1;
      end
      if (rcv_credit_valid_i) begin
        credit_d = credit_d + rcv_credit_i;
      end
    end
  end

  //////////////////////////////
  // Flit sequencer
  //////////////////////////////

  assign flit_last = tx_flit_ready_i && (flit_cnt_q == 3'(LastFlit));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q   <= credit_t'(`SLINK_NUM_CREDITS);
      busy_q     <= 1'b0;
      flit_cnt_q <= '0;
    end else begin
      credit_q <= credit_d;
      if (start) begin
        busy_q     <= 1'b1;
        flit_cnt_q <= '0;
      end else if (tx_flit_ready_i) begin
        flit_cnt_q <= flit_cnt_q + 1'b1;
        if (flit_last) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Flit 0 sits in the top byte and leaves first
  always_ff @(posedge clk_i) begin
    if (start) begin
      frame_q <= frame_d;
    end else if (tx_flit_ready_i) begin
      frame_q <= frame_q << `SLINK_NUM_LANES;
    end
  end

  assign tx_flit_o       = frame_q[$bits(frame_t)-1 -: `SLINK_NUM_LANES];
  assign tx_flit_valid_o = busy_q;
  assign credit_o        = credit_q;

  // Returned credits never exceed the slots of the far-end FIFO
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_q <= credit_t'(`SLINK_NUM_CREDITS));

endmodule

// ==== slink_phy.sv ====
/*
 * Physical layer of the serial link. Drives one flit per forwarded-clock period
 * on the lanes and samples the incoming lanes with a synchronized copy
 * of the received forwarded clock.
 */
`timescale 1ns/1ns

module slink_phy (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                link_en_i,
  input  slink_pkg::clk_div_t clk_div_i,
  input  slink_pkg::flit_t    tx_flit_i,
  input  logic                tx_flit_valid_i,
  output logic                tx_flit_ready_o,
  output logic                ddr_rcv_clk_o,
  output slink_pkg::flit_t    ddr_o,
  input  logic                ddr_rcv_clk_i,
  input  slink_pkg::flit_t    ddr_i,
  output slink_pkg::flit_t    rx_flit_o,
  output logic                rx_flit_valid_o
);

  import slink_pkg::*;

  clk_div_t div_cnt_q;
  clk_div_t half_div;
  logic     sending_q;
  logic     period_end;
  logic     take;
  logic     fwd_clk_q;
  flit_t    lanes_q;
  logic     rcv_clk_s1_q;
  logic     rcv_clk_s2_q;
  logic     rcv_clk_s3_q;
  flit_t    lanes_s1_q;
  flit_t    lanes_s2_q;
  logic     rcv_rise;
  flit_t    rx_flit_q;
  logic     rx_valid_q;

  //////////////////////////////
  // Transmit side
  //////////////////////////////

  assign half_div   = clk_div_i >> 1;
  assign period_end = sending_q && (div_cnt_q == clk_div_i - 1'b1);

  // Next flit is taken at the start of a period, back to back if one is waiting
  assign take            = link_en_i && tx_flit_valid_i && (!sending_q || period_end);
  assign tx_flit_ready_o = take;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sending_q <= 1'b0;
      div_cnt_q <= '0;
      fwd_clk_q <= 1'b0;
      lanes_q   <= '0;
    end else if (take) begin
      // Falling forwarded edge together with the new lane value
      sending_q <= 1'b1;
      div_cnt_q <= '0;
      fwd_clk_q <= 1'b0;
      lanes_q   <= tx_flit_i;
    end else if (period_end) begin
      // Nothing more to send, park the clock low
      sending_q <= 1'b0;
      div_cnt_q <= '0;
      fwd_clk_q <= 1'b0;
    end else if (sending_q) begin
      div_cnt_q <= div_cnt_q + 1'b1;
      // Rising edge half a period in, lanes already stable
      if (div_cnt_q == half_div - 1'b1) begin
        fwd_clk_q <= 1'b1;
      end
    end
  end

  assign ddr_rcv_clk_o = fwd_clk_q;
  assign ddr_o         = lanes_q;

  //////////////////////////////
  // Receive side
  //////////////////////////////

  // Clock and lanes go through the same two-flop depth to stay aligned
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rcv_clk_s1_q <= 1'b0;
      rcv_clk_s2_q <= 1'b0;
      rcv_clk_s3_q <= 1'b0;
      rx_valid_q   <= 1'b0;
    end else begin
      rcv_clk_s1_q <= ddr_rcv_clk_i;
      rcv_clk_s2_q <= rcv_clk_s1_q;
      rcv_clk_s3_q <= rcv_clk_s2_q;
      rx_valid_q   <= rcv_rise;
    end
  end

  always_ff @(posedge clk_i) begin
    lanes_s1_q <= ddr_i;
    lanes_s2_q <= lanes_s1_q;
    if (rcv_rise) begin
      rx_flit_q <= lanes_s2_q;
    end
  end

  assign rcv_rise        = rcv_clk_s2_q && !rcv_clk_s3_q;  // edge detect
  assign rx_flit_o       = rx_flit_q;
  assign rx_flit_valid_o = rx_valid_q;

endmodule

// ==== slink_pkg.sv ====
/*
 * Shared types of the serial link, covering lane, word, credit and frame vectors
 * and the frame tag and receive FSM encodings.
 */
`include "slink_config.svh"

package slink_pkg;

  // One beat on the lanes
  typedef logic [`SLINK_NUM_LANES-1:0] flit_t;

  // Stream word and register data
  typedef logic [`SLINK_DATA_W-1:0] data_t;

  // Credit counts from 0 up to the FIFO depth
  typedef logic [$clog2(`SLINK_NUM_CREDITS+1)-1:0] credit_t;

  typedef logic [7:0] clk_div_t;
  typedef logic [1:0] reg_addr_t;

  // Tag in bit 39, credit in 38..35, pad, data in 31..0
  typedef logic [`SLINK_FRAME_FLITS*`SLINK_NUM_LANES-1:0] frame_t;

  typedef enum logic {
    TAG_CREDIT = 1'b0,
    TAG_DATA   = 1'b1
  } tag_e;

  typedef enum logic {
    RX_IDLE    = 1'b0,
    RX_COLLECT = 1'b1
  } rx_state_e;

endpackage

// ==== slink_reg.sv ====
/*
 * Configuration and status registers of the serial link behind a strobe port.
 * Writes land at the clock edge, reads return one cycle later with reg_rvalid_o.
 */
`timescale 1ns/1ns
`include "slink_config.svh"

module slink_reg (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 reg_req_i,
  input  logic                 reg_we_i,
  input  slink_pkg::reg_addr_t reg_addr_i,
  input  slink_pkg::data_t     reg_wdata_i,
  output slink_pkg::data_t     reg_rdata_o,
  output logic                 reg_rvalid_o,
  input  slink_pkg::credit_t   tx_credit_i,
  input  slink_pkg::credit_t   rx_fill_i,
  output logic                 link_en_o,
  output slink_pkg::clk_div_t  clk_div_o,
  output logic                 fc_clear_o,
  output logic                 clk_ena_o,
  output logic                 reset_no
);

  import slink_pkg::*;

  logic     wr_ctrl;
  logic     wr_clk_div;
  logic     rd_req;
  logic     link_en_q;
  logic     clk_ena_q;
  logic     reset_n_q;
  logic     fc_clear_q;
  clk_div_t clk_div_q;
  data_t    rdata_d;
  data_t    rdata_q;
  logic     rvalid_q;

  assign wr_ctrl    = reg_req_i && reg_we_i && (reg_addr_i == `SLINK_REG_CTRL);
  assign wr_clk_div = reg_req_i && reg_we_i && (reg_addr_i == `SLINK_REG_CLK_DIV);
  assign rd_req     = reg_req_i && !reg_we_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      link_en_q  <= 1'b0;
      clk_ena_q  <= 1'b0;
      reset_n_q  <= 1'b0;
      fc_clear_q <= 1'b0;
      clk_div_q  <= clk_div_t'(`SLINK_CLK_DIV_RST);
      rvalid_q   <= 1'b0;
    end else begin
      // Clear bit is not stored, it only fires a pulse
      fc_clear_q <= wr_ctrl && reg_wdata_i[3];
      rvalid_q   <= rd_req;
      if (wr_ctrl) begin
        link_en_q <= reg_wdata_i[0];
        clk_ena_q <= reg_wdata_i[1];
        reset_n_q <= reg_wdata_i[2];
      end
      if (wr_clk_div) begin
        clk_div_q <= reg_wdata_i[7:0];
      end
    end
  end

  // Read mux
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      `SLINK_REG_CTRL:    rdata_d[2:0] = {reset_n_q, clk_ena_q, link_en_q};
      `SLINK_REG_CLK_DIV: rdata_d[7:0] = clk_div_q;
      `SLINK_REG_STATUS:  rdata_d[7:0] = {rx_fill_i, tx_credit_i};
      default:            rdata_d      = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;
  assign link_en_o    = link_en_q;
  assign clk_div_o    = clk_div_q;
  assign fc_clear_o   = fc_clear_q;
  assign clk_ena_o    = clk_ena_q;
  assign reset_no     = reset_n_q;

  // The forwarded clock needs two equal halves of at least two cycles each
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_clk_div |=> (clk_div_o[0] == 1'b0) && (clk_div_o >= 8'd4));

endmodule

// ==== tb_slink.sv ====
/*
 * Loopback testbench of the serial link. One DUT talks to itself through its lanes
 * and forwarded clock, a model queue and credit arithmetic give the expected results.
 */
`timescale 1ns/1ns
`include "slink_config.svh"

module tb_slink;

  import slink_pkg::*;

  // The longest section sends 20 words at divider 10. Each word costs a data frame and a
  // credit frame of 5 flits each plus sync delay, about 110 cycles. All sections with
  // their settle windows stay near 6000 cycles, so 20000 leaves a wide margin.
  localparam int unsigned TimeoutCycles = 20000;

  localparam int ReadyOn     = 0;
  localparam int ReadyRandom = 1;
  localparam int ReadyLow    = 2;

  logic        clk;
  logic        arst_n_i;
  data_t       data_i;
  logic        data_valid_i;
  logic        data_ready_o;
  data_t       data_o;
  logic        data_valid_o;
  logic        data_ready_i = 1'b0;
  logic        reg_req_i;
  logic        reg_we_i;
  reg_addr_t   reg_addr_i;
  data_t       reg_wdata_i;
  data_t       reg_rdata_o;
  logic        reg_rvalid_o;
  logic        fwd_clk;
  flit_t       lanes;
  logic        clk_ena_o;
  logic        reset_no;
  int          ready_mode;
  int unsigned cycle_cnt;
  data_t       sent_q[$];

  // Lanes and forwarded clock looped back onto the receive side
  slink uut (
    .clk_i         (clk),
    .arst_n_i      (arst_n_i),
    .data_i        (data_i),
    .data_valid_i  (data_valid_i),
    .data_ready_o  (data_ready_o),
    .data_o        (data_o),
    .data_valid_o  (data_valid_o),
    .data_ready_i  (data_ready_i),
    .reg_req_i     (reg_req_i),
    .reg_we_i      (reg_we_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_rdata_o   (reg_rdata_o),
    .reg_rvalid_o  (reg_rvalid_o),
    .ddr_rcv_clk_i (fwd_clk),
    .ddr_rcv_clk_o (fwd_clk),
    .ddr_i         (lanes),
    .ddr_o         (lanes),
    .clk_ena_o     (clk_ena_o),
    .reset_no      (reset_no)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // Reference and checks
  //////////////////////////////

  // Expected STATUS of a quiet link that still holds the given number of words
  function automatic data_t expected_status(input int unsigned outstanding);
    credit_t fill;
    credit_t credits;
    data_t   status;
    fill       = credit_t'(outstanding);
    credits    = credit_t'(`SLINK_NUM_CREDITS - outstanding);
    status     = '0;
    status[7:0] = {fill, credits};
    return status;
  endfunction

  task automatic check_eq(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Records accepted words and compares every output transfer
  always @(negedge clk) begin
    if (arst_n_i) begin
      if (data_valid_i && data_ready_o) begin
        sent_q.push_back(data_i);
      end
      if (data_valid_o && data_ready_i) begin
        if (sent_q.size() == 0) begin
          $display("Output word %h arrived while no word was outstanding", data_o);
          $display("Testbench failed");
          $fatal(1, "unexpected output word");
        end else begin
          check_eq(data_o, sent_q.pop_front(), "loopback word");
        end
      end
    end
  end

  // Back-pressure on the output stream
  always @(posedge clk) begin
    case (ready_mode)
      ReadyOn:     data_ready_i <= 1'b1;
      ReadyRandom: data_ready_i <= ($urandom_range(3) != 0);
      default:     data_ready_i <= 1'b0;
    endcase
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout, the run did not finish within %0d cycles", TimeoutCycles);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic reg_write(input reg_addr_t addr, input data_t wdata);
    @(posedge clk);
    reg_req_i   <= 1'b1;
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    @(posedge clk);
    reg_req_i <= 1'b0;
    reg_we_i  <= 1'b0;
    @(negedge clk);
  endtask

  task automatic read_check(input reg_addr_t addr, input data_t expected, input string what);
    @(posedge clk);
    reg_req_i  <= 1'b1;
    reg_we_i   <= 1'b0;
    reg_addr_i <= addr;
    @(posedge clk);
    reg_req_i <= 1'b0;
    @(negedge clk);
    check_eq(data_t'(reg_rvalid_o), 32'd1, "read valid");
    check_eq(reg_rdata_o, expected, what);
    @(negedge clk);
    check_eq(data_t'(reg_rvalid_o), 32'd0, "read valid one cycle later");
  endtask

  // Each word waits for its own transfer before the next one is driven
  task automatic send_words(input int unsigned count);
    for (int unsigned i = 0; i < count; i++) begin
      @(posedge clk);
      data_i       <= $urandom;
      data_valid_i <= 1'b1;
      @(negedge clk);
      while (!data_ready_o) @(negedge clk);
    end
    @(posedge clk);
    data_valid_i <= 1'b0;
  endtask

  task automatic wait_drained(input int unsigned settle_cycles);
    while (sent_q.size() != 0) @(negedge clk);
    repeat (settle_cycles) @(negedge clk);
  endtask

  task automatic hold_not_ready(input int unsigned cycles, input bit check_fwd_clk);
    repeat (cycles) begin
      @(negedge clk);
      check_eq(data_t'(data_ready_o), 32'd0, "data_ready_o while blocked");
      if (check_fwd_clk) begin
        check_eq(data_t'(fwd_clk), 32'd0, "ddr_rcv_clk_o with link disabled");
      end
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h6f346f14));
    clk          = 1'b0;
    arst_n_i     = 1'b0;
    data_i       = '0;
    data_valid_i = 1'b0;
    reg_req_i    = 1'b0;
    reg_we_i     = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    ready_mode   = ReadyLow;
    cycle_cnt    = 0;
    repeat (4) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);

    // Reset values
    check_eq(data_t'(clk_ena_o), 32'd0, "clk_ena_o after reset");
    check_eq(data_t'(reset_no), 32'd0, "reset_no after reset");
    check_eq(data_t'(data_ready_o), 32'd0, "data_ready_o after reset");
    check_eq(data_t'(data_valid_o), 32'd0, "data_valid_o after reset");
    check_eq(data_t'(fwd_clk), 32'd0, "ddr_rcv_clk_o after reset");
    check_eq(data_t'(lanes), 32'd0, "ddr_o after reset");
    read_check(`SLINK_REG_CTRL, 32'h0, "CTRL after reset");
    read_check(`SLINK_REG_CLK_DIV, data_t'(`SLINK_CLK_DIV_RST), "CLK_DIV after reset");
    read_check(`SLINK_REG_STATUS, expected_status(0), "STATUS after reset");

    // Register read back with the clear bit set
    reg_write(`SLINK_REG_CTRL, 32'hE);
    read_check(`SLINK_REG_CTRL, 32'h6, "CTRL read back");
    check_eq(data_t'(clk_ena_o), 32'd1, "clk_ena_o");
    check_eq(data_t'(reset_no), 32'd1, "reset_no");
    reg_write(`SLINK_REG_CLK_DIV, 32'd6);
    read_check(`SLINK_REG_CLK_DIV, 32'd6, "CLK_DIV read back");
    reg_write(`SLINK_REG_CLK_DIV, 32'd4);

    // Random words with random output stalls
    reg_write(`SLINK_REG_CTRL, 32'h7);
    ready_mode = ReadyRandom;
    send_words(40);
    wait_drained(100);
    read_check(`SLINK_REG_STATUS, expected_status(sent_q.size()), "STATUS after stream");

    // Blocked output lets the FIFO take exactly the credit count
    @(negedge clk);
    ready_mode = ReadyLow;
    send_words(`SLINK_NUM_CREDITS);
    hold_not_ready(150, 1'b0);
    read_check(`SLINK_REG_STATUS, expected_status(sent_q.size()), "STATUS with full FIFO");
    @(negedge clk);
    ready_mode = ReadyOn;
    wait_drained(100);
    read_check(`SLINK_REG_STATUS, expected_status(sent_q.size()), "STATUS after drain");

    // Slower forwarded clock
    reg_write(`SLINK_REG_CLK_DIV, 32'd10);
    ready_mode = ReadyRandom;
    send_words(20);
    wait_drained(250);
    read_check(`SLINK_REG_STATUS, expected_status(sent_q.size()), "STATUS at divider 10");

    // A disabled link takes no waiting word
    reg_write(`SLINK_REG_CTRL, 32'h6);
    @(posedge clk);
    data_i       <= $urandom;
    data_valid_i <= 1'b1;
    hold_not_ready(200, 1'b1);

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
slink_pkg.sv
slink_reg.sv
slink_link_tx.sv
slink_link_rx.sv
slink_phy.sv
slink.sv
tb_slink.sv
